//--- logic/alu_execute.sv
`default_nettype none

module alu_execute (
	input  logic op_valid,
	input  mips_pkg::exec_op_t op,
	output logic res_valid,
	output mips_pkg::wb_t res
);

	logic [mips_pkg::XLEN-1:0] a;
	logic [mips_pkg::XLEN-1:0] b;
	logic [mips_pkg::XLEN-1:0] result;

	assign a = op.operand_a;
	assign b = op.operand_b;

	always_comb begin
		case (op.alu_op)
			mips_pkg::ALU_ADD: result = a + b; // Wraps, no overflow trap
			mips_pkg::ALU_SUB: result = a - b;
			mips_pkg::ALU_AND: result = a & b;
			mips_pkg::ALU_OR: result = a | b;
			mips_pkg::ALU_XOR: result = a ^ b;
			mips_pkg::ALU_NOR: result = ~(a | b);
			mips_pkg::ALU_SLT: begin
				result = {{(mips_pkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			end
			mips_pkg::ALU_SLTU: begin
				result = {{(mips_pkg::XLEN-1){1'b0}}, a < b};
			end
			mips_pkg::ALU_SLL: result = a << op.shamt;
			mips_pkg::ALU_SRL: result = a >> op.shamt;
			mips_pkg::ALU_SRA: result = $signed(a) >>> op.shamt; // Sign fill
			mips_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	assign res_valid = op_valid & op.writes;
	assign res = '{dest: op.dest, data: result, writes: op.writes};

	// Set-less-than results must be boolean
	always_comb begin
		if (res_valid && (op.alu_op == mips_pkg::ALU_SLT || op.alu_op == mips_pkg::ALU_SLTU)) begin
			a_slt_bool: assert (res.data[mips_pkg::XLEN-1:1] == '0)
				else $error("SLT result 0x%08h is not 0 or 1", res.data);
		end
	end

endmodule

`default_nettype wire

//--- logic/insn_decoder.sv
`default_nettype none

module insn_decoder (
	input  logic insn_valid,
	input  logic [mips_pkg::XLEN-1:0] insn,
	input  logic [mips_pkg::XLEN-1:0] rd_data_a,
	input  logic [mips_pkg::XLEN-1:0] rd_data_b,
	input  logic ex_valid,
	input  logic [mips_pkg::REG_ADDR_W-1:0] ex_dest,
	input  logic [mips_pkg::XLEN-1:0] ex_data,
	input  logic wb_valid,
	input  logic [mips_pkg::REG_ADDR_W-1:0] wb_dest,
	input  logic [mips_pkg::XLEN-1:0] wb_data,
	output logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_a,
	output logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_b,
	output logic op_valid,
	output mips_pkg::exec_op_t op
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [mips_pkg::REG_ADDR_W-1:0] rs;
	logic [mips_pkg::REG_ADDR_W-1:0] rt;
	logic [mips_pkg::REG_ADDR_W-1:0] rd;
	logic [4:0] sa;
	logic [15:0] imm;
	logic [mips_pkg::XLEN-1:0] src_a;
	logic [mips_pkg::XLEN-1:0] src_b;
	logic supported;

	assign opcode = insn[31:26];
	assign rs = insn[25:21];
	assign rt = insn[20:16];
	assign rd = insn[15:11];
	assign sa = insn[10:6];
	assign funct = insn[5:0];
	assign imm = insn[15:0];

	assign rd_addr_a = rs;
	assign rd_addr_b = rt;

	// Youngest producer wins
	function automatic logic [mips_pkg::XLEN-1:0] forward(
		input logic [mips_pkg::REG_ADDR_W-1:0] addr,
		input logic [mips_pkg::XLEN-1:0] rf_data
	);
		if (addr != '0 && ex_valid && ex_dest == addr) begin
			return ex_data;
		end else if (addr != '0 && wb_valid && wb_dest == addr) begin
			return wb_data;
		end
		return rf_data;
	endfunction

	always_comb begin
		src_a = forward(rs, rd_data_a);
		src_b = forward(rt, rd_data_b);
	end

	always_comb begin
		supported = 1'b1;
		op.alu_op = mips_pkg::ALU_ADD;
		op.operand_a = src_a;
		op.operand_b = src_b;
		op.shamt = '0;
		op.dest = rt; // I-type target
		case (opcode)
			mips_pkg::RTYPE: begin
				op.dest = rd;
				case (funct)
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU: op.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU: op.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND: op.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR: op.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR: op.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_NOR: op.alu_op = mips_pkg::ALU_NOR;
					mips_pkg::FN_SLT: op.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: op.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
						// Shifts take rt and the sa field
						op.operand_a = src_b;
						op.shamt = sa;
						if (funct == mips_pkg::FN_SLL) begin
							op.alu_op = mips_pkg::ALU_SLL;
						end else if (funct == mips_pkg::FN_SRL) begin
							op.alu_op = mips_pkg::ALU_SRL;
						end else begin
							op.alu_op = mips_pkg::ALU_SRA;
						end
					end
					default: supported = 1'b0;
				endcase
			end
			mips_pkg::ADDI, mips_pkg::ADDIU: op.operand_b = {{16{imm[15]}}, imm};
			mips_pkg::SLTI: begin
				op.alu_op = mips_pkg::ALU_SLT;
				op.operand_b = {{16{imm[15]}}, imm};
			end
			mips_pkg::SLTIU: begin
				op.alu_op = mips_pkg::ALU_SLTU;
				op.operand_b = {{16{imm[15]}}, imm}; // Sign-extended, then compared unsigned
			end
			mips_pkg::ORI: begin
				op.alu_op = mips_pkg::ALU_OR;
				op.operand_b = {16'h0000, imm};
			end
			mips_pkg::XORI: begin
				op.alu_op = mips_pkg::ALU_XOR;
				op.operand_b = {16'h0000, imm};
			end
			mips_pkg::LUI: begin
				op.alu_op = mips_pkg::ALU_LUI;
				op.operand_b = {16'h0000, imm};
			end
			default: supported = 1'b0;
		endcase
		if (insn == '0) begin
			supported = 1'b0; // NOP
		end
		op.writes = supported;
	end

	assign op_valid = insn_valid & supported;

endmodule

`default_nettype wire

//--- logic/mips_core.sv
`default_nettype none

module mips_core (
	input  logic clock,
	input  logic rst_n,
	input  logic insn_valid,
	input  logic [mips_pkg::XLEN-1:0] insn,
	output logic wb_valid,
	output logic [mips_pkg::REG_ADDR_W-1:0] wb_reg,
	output logic [mips_pkg::XLEN-1:0] wb_data
);

	logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_a;
	logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_b;
	logic [mips_pkg::XLEN-1:0] rd_data_a;
	logic [mips_pkg::XLEN-1:0] rd_data_b;

	logic dec_valid;
	mips_pkg::exec_op_t dec_op;
	logic ex_stage_valid;
	mips_pkg::exec_op_t ex_op;
	logic res_valid;
	mips_pkg::wb_t res;
	mips_pkg::wb_t wb_payload;

	insn_decoder u_decoder (
		.insn_valid (insn_valid),
		.insn (insn),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.ex_valid (res_valid), // ALU output, one stage ahead
		.ex_dest (res.dest),
		.ex_data (res.data),
		.wb_valid (wb_valid),
		.wb_dest (wb_payload.dest),
		.wb_data (wb_payload.data),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.op_valid (dec_valid),
		.op (dec_op)
	);

	stage_register #(.payload_t(mips_pkg::exec_op_t)) u_ex_stage (
		.clock (clock),
		.rst_n (rst_n),
		.in_valid (dec_valid),
		.in_payload (dec_op),
		.out_valid (ex_stage_valid),
		.out_payload (ex_op)
	);

	alu_execute u_alu (
		.op_valid (ex_stage_valid),
		.op (ex_op),
		.res_valid (res_valid),
		.res (res)
	);

	stage_register #(.payload_t(mips_pkg::wb_t)) u_wb_stage (
		.clock (clock),
		.rst_n (rst_n),
		.in_valid (res_valid),
		.in_payload (res),
		.out_valid (wb_valid),
		.out_payload (wb_payload)
	);

	register_file u_regs (
		.clock (clock),
		.rst_n (rst_n),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.wr_en (wb_valid),
		.wr_addr (wb_payload.dest),
		.wr_data (wb_payload.data),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b)
	);

	assign wb_reg = wb_payload.dest;
	assign wb_data = wb_payload.data;

endmodule

`default_nettype wire

//--- logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS = 32;

	// Opcodes
	localparam logic [5:0] RTYPE = 6'b000000;
	localparam logic [5:0] ADDI = 6'b001000;
	localparam logic [5:0] ADDIU = 6'b001001;
	localparam logic [5:0] SLTI = 6'b001010;
	localparam logic [5:0] SLTIU = 6'b001011;
	localparam logic [5:0] ORI = 6'b001101;
	localparam logic [5:0] XORI = 6'b001110;
	localparam logic [5:0] LUI = 6'b001111;

	// R-type function codes
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_e;

	// Decode to execute, 79 bits
	typedef struct packed {
		alu_op_e alu_op;
		logic [XLEN-1:0] operand_a;
		logic [XLEN-1:0] operand_b;
		logic [4:0] shamt;
		logic [REG_ADDR_W-1:0] dest;
		logic writes;
	} exec_op_t;

	// Execute to write-back, 38 bits
	typedef struct packed {
		logic [REG_ADDR_W-1:0] dest;
		logic [XLEN-1:0] data;
		logic writes;
	} wb_t;

endpackage

`default_nettype wire

//--- logic/register_file.sv
`default_nettype none

module register_file (
	input  logic clock,
	input  logic rst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_a,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rd_addr_b,
	input  logic wr_en,
	input  logic [mips_pkg::REG_ADDR_W-1:0] wr_addr,
	input  logic [mips_pkg::XLEN-1:0] wr_data,
	output logic [mips_pkg::XLEN-1:0] rd_data_a,
	output logic [mips_pkg::XLEN-1:0] rd_data_b
);

	logic [mips_pkg::XLEN-1:0] regs [0:mips_pkg::NUM_REGS-1];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != '0) begin // r0 is hardwired
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads are plain lookups, forwarding happens in decode
	assign rd_data_a = regs[rd_addr_a];
	assign rd_data_b = regs[rd_addr_b];

	// A write aimed at r0 must leave it at zero
	a_r0_zero: assert property (@(posedge clock) disable iff (!rst_n)
		(wr_en && wr_addr == '0) |=> (regs[0] == '0));

endmodule

`default_nettype wire

//--- logic/stage_register.sv
`default_nettype none

module stage_register #(
	parameter type payload_t = logic
) (
	input  logic clock,
	input  logic rst_n,
	input  logic in_valid,
	input  payload_t in_payload,
	output logic out_valid,
	output payload_t out_payload
);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// Payload only loads on a valid beat
	always_ff @(posedge clock) begin
		if (in_valid) begin
			out_payload <= in_payload;
		end
	end

	a_valid_known: assert property (@(posedge clock) disable iff (!rst_n)
		!$isunknown(out_valid));

endmodule

`default_nettype wire

//--- mips_core.f
logic/mips_pkg.sv
logic/register_file.sv
logic/insn_decoder.sv
logic/stage_register.sv
logic/alu_execute.sv
logic/mips_core.sv
test/mips_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_core_tb -f mips_core.f

./obj_dir/Vmips_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"

//--- test/mips_core_tb.sv
`default_nettype none

module mips_core_tb;

	localparam int PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RAND_COUNT = 300;

	localparam logic [5:0] R_FUNCTS [13] = '{
		mips_pkg::FN_ADD, mips_pkg::FN_ADDU, mips_pkg::FN_SUB, mips_pkg::FN_SUBU,
		mips_pkg::FN_AND, mips_pkg::FN_OR, mips_pkg::FN_XOR, mips_pkg::FN_NOR,
		mips_pkg::FN_SLT, mips_pkg::FN_SLTU, mips_pkg::FN_SLL, mips_pkg::FN_SRL,
		mips_pkg::FN_SRA
	};
	localparam logic [5:0] I_OPS [7] = '{
		mips_pkg::ADDI, mips_pkg::ADDIU, mips_pkg::SLTI, mips_pkg::SLTIU,
		mips_pkg::ORI, mips_pkg::XORI, mips_pkg::LUI
	};

	typedef struct packed {
		logic valid;
		logic [mips_pkg::XLEN-1:0] insn;
		logic we;
		logic [mips_pkg::REG_ADDR_W-1:0] dest;
		logic [mips_pkg::XLEN-1:0] data;
	} step_t;

	logic clock;
	logic rst_n;
	logic insn_valid;
	logic [mips_pkg::XLEN-1:0] insn;
	logic wb_valid;
	logic [mips_pkg::REG_ADDR_W-1:0] wb_reg;
	logic [mips_pkg::XLEN-1:0] wb_data;

	step_t directed [$];
	step_t pending [$]; // Expected write-backs still in flight
	logic [mips_pkg::XLEN-1:0] model_regs [0:mips_pkg::NUM_REGS-1];

	mips_core u_dut (
		.clock (clock),
		.rst_n (rst_n),
		.insn_valid (insn_valid),
		.insn (insn),
		.wb_valid (wb_valid),
		.wb_reg (wb_reg),
		.wb_data (wb_data)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rd,
			input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sa);
		return {mips_pkg::RTYPE, rs, rt, rd, sa, funct};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] opcode, input logic [4:0] rt,
			input logic [4:0] rs, input logic [15:0] imm);
		return {opcode, rs, rt, imm};
	endfunction

	function automatic step_t bubble(input logic [31:0] word);
		step_t s;
		s.valid = 1'b0;
		s.insn = word;
		s.we = 1'b0;
		s.dest = '0;
		s.data = '0;
		return s;
	endfunction

	// Reference model applied in program order
	function automatic step_t predict(input logic [31:0] word);
		step_t s;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] zimm;
		logic [4:0] sa;
		a = model_regs[word[25:21]];
		b = model_regs[word[20:16]];
		sa = word[10:6];
		simm = {{16{word[15]}}, word[15:0]};
		zimm = {16'h0000, word[15:0]};
		s = bubble(word);
		s.valid = 1'b1;
		s.we = 1'b1;
		s.dest = word[20:16];
		case (word[31:26])
			mips_pkg::RTYPE: begin
				s.dest = word[15:11];
				case (word[5:0])
					mips_pkg::FN_ADD, mips_pkg::FN_ADDU: s.data = a + b;
					mips_pkg::FN_SUB, mips_pkg::FN_SUBU: s.data = a - b;
					mips_pkg::FN_AND: s.data = a & b;
					mips_pkg::FN_OR: s.data = a | b;
					mips_pkg::FN_XOR: s.data = a ^ b;
					mips_pkg::FN_NOR: s.data = ~(a | b);
					mips_pkg::FN_SLT: s.data = {31'b0, $signed(a) < $signed(b)};
					mips_pkg::FN_SLTU: s.data = {31'b0, a < b};
					mips_pkg::FN_SLL: s.data = b << sa;
					mips_pkg::FN_SRL: s.data = b >> sa;
					mips_pkg::FN_SRA: s.data = $signed(b) >>> sa;
					default: s.we = 1'b0;
				endcase
			end
			mips_pkg::ADDI, mips_pkg::ADDIU: s.data = a + simm;
			mips_pkg::SLTI: s.data = {31'b0, $signed(a) < $signed(simm)};
			mips_pkg::SLTIU: s.data = {31'b0, a < simm};
			mips_pkg::ORI: s.data = a | zimm;
			mips_pkg::XORI: s.data = a ^ zimm;
			mips_pkg::LUI: s.data = {word[15:0], 16'h0000};
			default: s.we = 1'b0;
		endcase
		if (word == '0) begin
			s.we = 1'b0; // NOP
		end
		return s;
	endfunction

	task automatic commit(input step_t s);
		if (s.valid && s.we && s.dest != 5'd0) begin
			model_regs[s.dest] = s.data;
		end
	endtask

	function automatic logic [31:0] random_insn();
		logic [4:0] pick;
		logic [31:0] f;
		pick = 5'($urandom_range(19));
		f = $urandom;
		if (pick < 5'd13) begin
			return r_type(R_FUNCTS[pick[3:0]], f[4:0], f[9:5], f[14:10], f[19:15]);
		end
		return i_type(I_OPS[3'(pick - 5'd13)], f[4:0], f[9:5], f[31:16]);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_wb(input step_t s);
		if (s.we) begin
			assert (wb_valid === 1'b1)
				else abort_run($sformatf("No write-back of r%0d at time %0t", s.dest, $time));
			assert (wb_reg === s.dest && wb_data === s.data)
				else abort_run($sformatf("FAILED at %0t: got r%0d = 0x%08h, expected r%0d = 0x%08h",
					$time, wb_reg, wb_data, s.dest, s.data));
		end else begin
			assert (wb_valid === 1'b0)
				else abort_run($sformatf("Unexpected write-back of r%0d at time %0t", wb_reg, $time));
		end
	endtask

	// Drive one step and check the step from two cycles back
	task automatic apply(input step_t s);
		@(posedge clock);
		#(DRIVE_DELAY);
		insn_valid = s.valid;
		insn = s.insn;
		pending.push_back(s);
		@(negedge clock);
		if (pending.size() > 2) begin
			check_wb(pending.pop_front());
		end
	endtask

	task automatic add_step(input logic valid, input logic [31:0] word, input logic we,
			input logic [4:0] dest, input logic [31:0] data);
		step_t s;
		s.valid = valid;
		s.insn = word;
		s.we = we;
		s.dest = dest;
		s.data = data;
		directed.push_back(s);
	endtask

	task automatic load_table();
		// Immediates from zero-valued sources
		add_step(1'b1, i_type(mips_pkg::ADDIU, 5'd1, 5'd0, 16'h7fff), 1'b1, 5'd1, 32'h0000_7fff);
		add_step(1'b1, i_type(mips_pkg::ADDIU, 5'd2, 5'd0, 16'h8000), 1'b1, 5'd2, 32'hffff_8000);
		add_step(1'b1, i_type(mips_pkg::ORI, 5'd3, 5'd0, 16'h8000), 1'b1, 5'd3, 32'h0000_8000);
		add_step(1'b1, i_type(mips_pkg::XORI, 5'd4, 5'd31, 16'hffff), 1'b1, 5'd4, 32'h0000_ffff);
		add_step(1'b1, i_type(mips_pkg::LUI, 5'd5, 5'd0, 16'h8000), 1'b1, 5'd5, 32'h8000_0000);
		add_step(1'b1, i_type(mips_pkg::LUI, 5'd6, 5'd0, 16'h1234), 1'b1, 5'd6, 32'h1234_0000);
		add_step(1'b1, i_type(mips_pkg::ORI, 5'd6, 5'd6, 16'h5678), 1'b1, 5'd6, 32'h1234_5678);
		// R-type corners
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd7, 5'd5, 5'd5, 5'd0), 1'b1, 5'd7, 32'h0);
		add_step(1'b1, r_type(mips_pkg::FN_ADD, 5'd8, 5'd2, 5'd2, 5'd0), 1'b1, 5'd8, 32'hffff_0000);
		add_step(1'b1, r_type(mips_pkg::FN_SUBU, 5'd9, 5'd0, 5'd1, 5'd0), 1'b1, 5'd9, 32'hffff_8001);
		add_step(1'b1, r_type(mips_pkg::FN_SUB, 5'd10, 5'd5, 5'd1, 5'd0), 1'b1, 5'd10, 32'h7fff_8001);
		add_step(1'b1, r_type(mips_pkg::FN_AND, 5'd11, 5'd6, 5'd2, 5'd0), 1'b1, 5'd11, 32'h1234_0000);
		add_step(1'b1, r_type(mips_pkg::FN_OR, 5'd12, 5'd1, 5'd3, 5'd0), 1'b1, 5'd12, 32'h0000_ffff);
		add_step(1'b1, r_type(mips_pkg::FN_XOR, 5'd13, 5'd2, 5'd4, 5'd0), 1'b1, 5'd13, 32'hffff_7fff);
		add_step(1'b1, r_type(mips_pkg::FN_NOR, 5'd14, 5'd0, 5'd0, 5'd0), 1'b1, 5'd14, 32'hffff_ffff);
		add_step(1'b1, r_type(mips_pkg::FN_SLT, 5'd15, 5'd5, 5'd1, 5'd0), 1'b1, 5'd15, 32'h1);
		add_step(1'b1, r_type(mips_pkg::FN_SLTU, 5'd16, 5'd5, 5'd1, 5'd0), 1'b1, 5'd16, 32'h0);
		add_step(1'b1, r_type(mips_pkg::FN_SLT, 5'd17, 5'd1, 5'd2, 5'd0), 1'b1, 5'd17, 32'h0);
		add_step(1'b1, r_type(mips_pkg::FN_SLTU, 5'd17, 5'd1, 5'd2, 5'd0), 1'b1, 5'd17, 32'h1);
		add_step(1'b1, i_type(mips_pkg::SLTI, 5'd18, 5'd2, 16'hffff), 1'b1, 5'd18, 32'h1);
		add_step(1'b1, i_type(mips_pkg::SLTIU, 5'd19, 5'd1, 16'hffff), 1'b1, 5'd19, 32'h1);
		// Shifts by 0, 1 and 31
		add_step(1'b1, r_type(mips_pkg::FN_SLL, 5'd20, 5'd0, 5'd6, 5'd0), 1'b1, 5'd20, 32'h1234_5678);
		add_step(1'b1, r_type(mips_pkg::FN_SLL, 5'd20, 5'd0, 5'd6, 5'd1), 1'b1, 5'd20, 32'h2468_acf0);
		add_step(1'b1, r_type(mips_pkg::FN_SLL, 5'd24, 5'd0, 5'd1, 5'd31), 1'b1, 5'd24, 32'h8000_0000);
		add_step(1'b1, r_type(mips_pkg::FN_SRL, 5'd21, 5'd0, 5'd5, 5'd1), 1'b1, 5'd21, 32'h4000_0000);
		add_step(1'b1, r_type(mips_pkg::FN_SRL, 5'd23, 5'd0, 5'd5, 5'd31), 1'b1, 5'd23, 32'h1);
		add_step(1'b1, r_type(mips_pkg::FN_SRA, 5'd22, 5'd0, 5'd5, 5'd1), 1'b1, 5'd22, 32'hc000_0000);
		add_step(1'b1, r_type(mips_pkg::FN_SRA, 5'd22, 5'd0, 5'd5, 5'd31), 1'b1, 5'd22, 32'hffff_ffff);
		add_step(1'b1, r_type(mips_pkg::FN_SRA, 5'd25, 5'd0, 5'd6, 5'd31), 1'b1, 5'd25, 32'h0);
		add_step(1'b1, r_type(mips_pkg::FN_SRA, 5'd23, 5'd0, 5'd5, 5'd0), 1'b1, 5'd23, 32'h8000_0000);
		add_step(1'b1, r_type(mips_pkg::FN_SRL, 5'd24, 5'd0, 5'd2, 5'd0), 1'b1, 5'd24, 32'hffff_8000);
		add_step(1'b1, r_type(mips_pkg::FN_SLL, 5'd21, 5'd0, 5'd2, 5'd1), 1'b1, 5'd21, 32'hffff_0000);
		// Dependent chains at distance 1, 2 and 3
		add_step(1'b1, i_type(mips_pkg::ADDIU, 5'd26, 5'd0, 16'h0001), 1'b1, 5'd26, 32'h1);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd26, 5'd26, 5'd26, 5'd0), 1'b1, 5'd26, 32'h2);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd27, 5'd26, 5'd26, 5'd0), 1'b1, 5'd27, 32'h4);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd28, 5'd26, 5'd27, 5'd0), 1'b1, 5'd28, 32'h6);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd29, 5'd26, 5'd28, 5'd0), 1'b1, 5'd29, 32'h8);
		add_step(1'b0, 32'h0, 1'b0, 5'd0, 32'h0);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd30, 5'd29, 5'd28, 5'd0), 1'b1, 5'd30, 32'he);
		add_step(1'b0, i_type(mips_pkg::ADDIU, 5'd1, 5'd0, 16'h0055), 1'b0, 5'd0, 32'h0); // Ignored
		add_step(1'b0, 32'h0, 1'b0, 5'd0, 32'h0);
		add_step(1'b1, r_type(mips_pkg::FN_SUBU, 5'd31, 5'd30, 5'd29, 5'd0), 1'b1, 5'd31, 32'h6);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd3, 5'd1, 5'd0, 5'd0), 1'b1, 5'd3, 32'h0000_7fff);
		// No write-back cases and r0 as target and source
		add_step(1'b1, 32'h0, 1'b0, 5'd0, 32'h0);
		add_step(1'b1, i_type(6'h23, 5'd2, 5'd1, 16'h0000), 1'b0, 5'd0, 32'h0);
		add_step(1'b1, r_type(6'h18, 5'd0, 5'd1, 5'd2, 5'd0), 1'b0, 5'd0, 32'h0);
		add_step(1'b1, i_type(mips_pkg::ADDIU, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd0, 32'h0000_8004);
		add_step(1'b1, r_type(mips_pkg::FN_ADDU, 5'd9, 5'd0, 5'd0, 5'd0), 1'b1, 5'd9, 32'h0);
		add_step(1'b1, i_type(mips_pkg::ORI, 5'd10, 5'd0, 16'h0001), 1'b1, 5'd10, 32'h1);
	endtask

	// A bubble may come before every random instruction
	initial begin
		@(posedge rst_n);
		#((directed.size() + 2 * RAND_COUNT + 10) * PERIOD);
		abort_run("Timeout: the run did not finish in the expected time");
	end

	initial begin
		step_t s;
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		void'($urandom(32'h5efe_71e1));
		for (int i = 0; i < mips_pkg::NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		load_table();
		repeat (3) @(posedge clock);
		#(DRIVE_DELAY);
		rst_n = 1'b1;
		pending.push_back(bubble('0)); // wb_valid must stay low right after reset
		pending.push_back(bubble('0));
		foreach (directed[i]) begin
			apply(directed[i]);
			if (directed[i].valid) begin
				commit(predict(directed[i].insn));
			end
		end
		for (int n = 0; n < RAND_COUNT; n++) begin
			if ($urandom_range(3) == 0) begin
				apply(bubble($urandom));
			end
			s = predict(random_insn());
			apply(s);
			commit(s);
		end
		apply(bubble('0)); // Drain
		apply(bubble('0));
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire
